// File: tb/weight_load_tests.txt
// columns in hex: layer type (0 pointwise, 1 depthwise, 2 standard, 3 linear),
// base byte address, abort count (0 runs to done), expected enable count
0 00000000 0 400
0 00000103 0 400
1 00000200 0 5a
1 000002a1 0 5a
2 00000040 6 0
3 00000011 6 0
0 000006ff 40 3f
1 00000031 14 13

// File: weight_load_controller.f
+incdir+src
src/wl_layer_pkg.sv
src/wl_glb_pkg.sv
src/weight_addr_gen.sv
src/weight_byte_select.sv
src/pe_enable_sequencer.sv
src/weight_load_controller.sv
tb/tb_weight_load_controller.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_weight_load_controller \
    -f weight_load_controller.f \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

// File: tb/tb_weight_load_controller.sv
`timescale 1ns/10ps

module tb_weight_load_controller;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int GAP_CYCLES   = 3;      // low cycles between two loads
    localparam int MAX_TESTS    = 32;
    localparam int GLB_WORDS    = 512;
    localparam int SEED         = 26934;

    logic                      clk;
    logic                      rst_n;
    logic                      load_state_i;
    wl_layer_pkg::layer_type_e layer_type_i;
    wl_glb_pkg::glb_addr_t     base_addr_i;
    wl_glb_pkg::glb_word_t     glb_rdata_i;
    wl_glb_pkg::glb_addr_t     glb_addr_o;
    wl_layer_pkg::pe_load_t    pe_load_o;
    logic                      load_done_o;

    wl_glb_pkg::glb_word_t glb_mem [0:GLB_WORDS-1];
    logic [31:0]           test_words [0:4*MAX_TESTS-1];   // four columns per test
    logic [8:0]            rd_index;

    int     num_tests;
    int     error_count;
    int     check_count;
    int     enables_seen;
    int     dones_seen;
    bit     tests_loaded;
    longint watchdog_ns;

    weight_load_controller i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_state_i (load_state_i),
        .layer_type_i (layer_type_i),
        .base_addr_i  (base_addr_i),
        .glb_rdata_i  (glb_rdata_i),
        .glb_addr_o   (glb_addr_o),
        .pe_load_o    (pe_load_o),
        .load_done_o  (load_done_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // glb read port, word of the address shown before the edge appears one cycle later
    always begin
        @(negedge clk);
        rd_index = glb_addr_o[10:2];
        @(posedge clk);
        #1;
        glb_rdata_i = glb_mem[rd_index];
    end

    function automatic int weights_for_layer(wl_layer_pkg::layer_type_e layer);
        case (layer)
            wl_layer_pkg::POINTWISE: return 1024;
            wl_layer_pkg::DEPTHWISE: return 90;    // 10 channels of 3x3
            default:                 return 0;
        endcase
    endfunction

    // one-hot matrix for weight n
    function automatic wl_layer_pkg::pe_en_matrix_t expected_enables(
        wl_layer_pkg::layer_type_e layer, int n);
        wl_layer_pkg::pe_en_matrix_t m;
        int                          row;
        int                          col;
        m = '0;
        if (layer == wl_layer_pkg::POINTWISE) begin
            row = n / 32;
            col = n % 32;
        end else begin
            // channel n/9 on the diagonal, columns filled bottom to top
            row = 3 * (n / 9) + 2 - (n % 9) % 3;
            col = 3 * (n / 9) + (n % 9) / 3;
        end
        m[row][col] = 1'b1;
        return m;
    endfunction

    function automatic logic [7:0] expected_weight(wl_glb_pkg::glb_addr_t addr);
        wl_glb_pkg::glb_word_t word;
        word = glb_mem[addr[10:2]];
        return word[8*addr[1:0] +: 8];
    endfunction

    // outputs while the DUT counter equals cnt
    task automatic check_load_cycle(input wl_layer_pkg::layer_type_e layer,
                                    input wl_glb_pkg::glb_addr_t base,
                                    input int cnt);
        int                          num;
        int                          n;
        wl_glb_pkg::glb_addr_t       exp_addr;
        wl_layer_pkg::pe_en_matrix_t exp_en;
        logic                        exp_done;
        num      = weights_for_layer(layer);
        n        = cnt - 2;   // weight whose enable is due now
        exp_addr = base + wl_glb_pkg::glb_addr_t'(cnt - 1);
        exp_en   = '0;
        if (n >= 0 && n < num) begin
            exp_en = expected_enables(layer, n);
        end
        exp_done = (num > 0) && (cnt == num + 2);
        check_count += 3;
        assert (glb_addr_o == exp_addr) else begin
            error_count++;
            $display("[ERROR] %0t: count %0d, glb_addr_o is %h, expected %h",
                     $time, cnt, glb_addr_o, exp_addr);
        end
        assert (pe_load_o.en_matrix == exp_en) else begin
            error_count++;
            $display("[ERROR] %0t: count %0d, wrong enable matrix (%0d bits set, %0d expected)",
                     $time, cnt, $countones(pe_load_o.en_matrix), $countones(exp_en));
        end
        assert (load_done_o == exp_done) else begin
            error_count++;
            $display("[ERROR] %0t: count %0d, load_done_o is %b, expected %b",
                     $time, cnt, load_done_o, exp_done);
        end
        if (exp_en != '0) begin
            check_count++;
            assert (pe_load_o.weight == expected_weight(base + wl_glb_pkg::glb_addr_t'(n)))
            else begin
                error_count++;
                $display("[ERROR] %0t: weight %0d is %h, expected %h", $time, n,
                         pe_load_o.weight,
                         expected_weight(base + wl_glb_pkg::glb_addr_t'(n)));
            end
        end
        if (pe_load_o.en_matrix != '0) enables_seen++;
        if (load_done_o) dones_seen++;
    endtask

    task automatic check_idle(input string what);
        check_count++;
        assert (pe_load_o.en_matrix == '0 && !load_done_o && glb_addr_o == '0) else begin
            error_count++;
            $display("[ERROR] %0t: outputs not cleared %s (enables %0d, done %b, addr %h)",
                     $time, what, $countones(pe_load_o.en_matrix), load_done_o, glb_addr_o);
        end
    endtask

    initial begin
        int                        cnt;
        int                        abort_cnt;
        int                        exp_count;
        int                        exp_dones;
        int                        num;
        bit                        stop;
        longint                    total;
        wl_layer_pkg::layer_type_e layer;
        wl_glb_pkg::glb_addr_t     base;

        rst_n        = 1'b0;
        load_state_i = 1'b0;
        layer_type_i = wl_layer_pkg::POINTWISE;
        base_addr_i  = '0;
        glb_rdata_i  = '0;
        error_count  = 0;
        check_count  = 0;
        enables_seen = 0;
        dones_seen   = 0;
        num_tests    = 0;
        tests_loaded = 1'b0;

        void'($urandom(SEED));
        for (int i = 0; i < GLB_WORDS; i++) begin
            glb_mem[i] = $urandom();
        end

        for (int i = 0; i < 4 * MAX_TESTS; i++) begin
            test_words[i] = '1;   // marks rows past the end of the file
        end
        $readmemh("tb/weight_load_tests.txt", test_words);
        while (num_tests < MAX_TESTS && test_words[4*num_tests] != '1) num_tests++;
        if (num_tests == 0) begin
            error_count++;
            $display("no tests found in tb/weight_load_tests.txt");
        end

        total = 0;
        for (int i = 0; i < num_tests; i++) begin
            total += longint'(test_words[4*i+3]) + 10;
        end
        watchdog_ns  = total * CLK_PERIOD;
        tests_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");

        for (int t = 0; t < num_tests; t++) begin
            layer        = wl_layer_pkg::layer_type_e'(test_words[4*t][1:0]);
            base         = test_words[4*t+1];
            abort_cnt    = int'(test_words[4*t+2]);
            exp_count    = int'(test_words[4*t+3]);
            num          = weights_for_layer(layer);
            enables_seen = 0;
            dones_seen   = 0;

            @(posedge clk);
            #1;
            load_state_i = 1'b1;
            layer_type_i = layer;
            base_addr_i  = base;
            cnt          = 0;
            stop         = 1'b0;
            while (!stop) begin
                @(posedge clk);
                cnt++;
                #1;
                if (load_done_o || (abort_cnt != 0 && cnt == abort_cnt)) begin
                    load_state_i = 1'b0;
                    stop         = 1'b1;
                end
                @(negedge clk);
                check_load_cycle(layer, base, cnt);
            end

            // first edge after the drop clears, the next load starts on the third
            repeat (GAP_CYCLES - 1) begin
                @(posedge clk);
                @(negedge clk);
                check_idle("after load");
            end

            exp_dones = (num > 0 && (abort_cnt == 0 || abort_cnt >= num + 2)) ? 1 : 0;
            check_count += 2;
            assert (enables_seen == exp_count) else begin
                error_count++;
                $display("[ERROR] %0t: test %0d saw %0d enables, expected %0d",
                         $time, t, enables_seen, exp_count);
            end
            assert (dones_seen == exp_dones) else begin
                error_count++;
                $display("[ERROR] %0t: test %0d saw %0d done pulses, expected %0d",
                         $time, t, dones_seen, exp_dones);
            end
        end

        $display("tests: %0d, checks: %0d, errors: %0d", num_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // bound on the whole run, taken from the expected load lengths
    initial begin
        wait (tests_loaded);
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: src/weight_load_controller.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module weight_load_controller (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_state_i,
    input  wl_layer_pkg::layer_type_e layer_type_i,
    input  wl_glb_pkg::glb_addr_t     base_addr_i,
    input  wl_glb_pkg::glb_word_t     glb_rdata_i,
    output wl_glb_pkg::glb_addr_t     glb_addr_o,
    output wl_layer_pkg::pe_load_t    pe_load_o,
    output logic                      load_done_o
);

    wl_layer_pkg::load_cnt_t     load_cnt;
    logic [`WL_WEIGHT_W-1:0]     weight;
    wl_layer_pkg::pe_en_matrix_t en_matrix;

    weight_addr_gen i_addr_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_state_i (load_state_i),
        .base_addr_i  (base_addr_i),
        .load_cnt_o   (load_cnt),
        .glb_addr_o   (glb_addr_o)
    );

    weight_byte_select i_byte_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr_lsb_i  (wl_glb_pkg::byte_lane_e'(glb_addr_o[1:0])),
        .glb_rdata_i (glb_rdata_i),
        .weight_o    (weight)
    );

    pe_enable_sequencer i_en_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_state_i (load_state_i),
        .layer_type_i (layer_type_i),
        .load_cnt_i   (load_cnt),
        .en_matrix_o  (en_matrix),
        .load_done_o  (load_done_o)
    );

    assign pe_load_o = '{weight: weight, en_matrix: en_matrix};

endmodule

// File: src/pe_enable_sequencer.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module pe_enable_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_state_i,
    input  wl_layer_pkg::layer_type_e   layer_type_i,
    input  wl_layer_pkg::load_cnt_t     load_cnt_i,
    output wl_layer_pkg::pe_en_matrix_t en_matrix_o,
    output logic                        load_done_o
);

    // enable of weight n is visible at count n + LEAD
    localparam int unsigned LEAD     = `WL_GLB_RD_LAT + 1;
    localparam int unsigned DW_BLOCK = `WL_DW_KERNEL * `WL_DW_KERNEL;

    wl_layer_pkg::load_cnt_t  cnt_nxt;      // count while the registered state is shown
    wl_layer_pkg::load_cnt_t  num_weights;
    wl_layer_pkg::load_cnt_t  widx;         // weight index for cnt_nxt
    wl_layer_pkg::pe_coord_t  coord;
    logic [3:0]               dw_k;         // depthwise channel
    logic [3:0]               dw_p;         // position inside the 3x3 kernel
    logic                     in_window;
    logic                     done_hit;

    always_comb begin
        case (layer_type_i)
            wl_layer_pkg::POINTWISE: num_weights = `WL_CNT_W'(`WL_PW_WEIGHTS);
            wl_layer_pkg::DEPTHWISE: num_weights = `WL_CNT_W'(`WL_DW_WEIGHTS);
            default:                 num_weights = '0;   // nothing to load
        endcase
    end

    assign cnt_nxt   = load_cnt_i + 1'b1;
    assign widx      = wl_layer_pkg::load_cnt_t'(cnt_nxt - LEAD);
    assign in_window = (cnt_nxt >= LEAD) && (cnt_nxt < num_weights + LEAD);
    assign done_hit  = (num_weights != '0) && (cnt_nxt == num_weights + LEAD);

    assign dw_k = 4'(widx / DW_BLOCK);
    assign dw_p = 4'(widx % DW_BLOCK);

    always_comb begin
        coord = '0;
        if (in_window) begin
            case (layer_type_i)
                wl_layer_pkg::POINTWISE: begin   // row-major fill
                    coord.row   = 5'(widx / `WL_PE_COLS);
                    coord.col   = 5'(widx % `WL_PE_COLS);
                    coord.valid = 1'b1;
                end
                wl_layer_pkg::DEPTHWISE: begin
                    // each column of diagonal block k filled bottom to top
                    coord.row   = 5'(`WL_DW_KERNEL * dw_k + (`WL_DW_KERNEL - 1)
                                     - dw_p % `WL_DW_KERNEL);
                    coord.col   = 5'(`WL_DW_KERNEL * dw_k + dw_p / `WL_DW_KERNEL);
                    coord.valid = 1'b1;
                end
                default: coord = '0;
            endcase
        end
    end

    // one-hot enable and done pulse both drop as soon as the level falls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_matrix_o <= '0;
            load_done_o <= 1'b0;
        end else if (!load_state_i) begin
            en_matrix_o <= '0;
            load_done_o <= 1'b0;
        end else begin
            en_matrix_o <= '0;   // previous slot has passed
            if (coord.valid) begin
                en_matrix_o[coord.row][coord.col] <= 1'b1;
            end
            load_done_o <= done_hit;
        end
    end

    a_en_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(en_matrix_o)
    );

endmodule

// File: src/weight_byte_select.sv
`timescale 1ns/10ps
`include "wl_consts.svh"

module weight_byte_select (
    input  logic                     clk,
    input  logic                     rst_n,
    input  wl_glb_pkg::byte_lane_e   addr_lsb_i,
    input  wl_glb_pkg::glb_word_t    glb_rdata_i,
    output logic [`WL_WEIGHT_W-1:0]  weight_o
);

    wl_glb_pkg::byte_lane_e lane_q;   // lane of the word now on the read bus

    // lane follows the address by the glb read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_q <= wl_glb_pkg::LANE0;
        end else begin
            lane_q <= addr_lsb_i;
        end
    end

    always_comb begin
        case (lane_q)
            wl_glb_pkg::LANE0: weight_o = glb_rdata_i[0*`WL_WEIGHT_W +: `WL_WEIGHT_W];
            wl_glb_pkg::LANE1: weight_o = glb_rdata_i[1*`WL_WEIGHT_W +: `WL_WEIGHT_W];
            wl_glb_pkg::LANE2: weight_o = glb_rdata_i[2*`WL_WEIGHT_W +: `WL_WEIGHT_W];
            wl_glb_pkg::LANE3: weight_o = glb_rdata_i[3*`WL_WEIGHT_W +: `WL_WEIGHT_W];
            default:           weight_o = '0;
        endcase
    end

endmodule

// File: src/weight_addr_gen.sv
`timescale 1ns/10ps

module weight_addr_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_state_i,
    input  wl_glb_pkg::glb_addr_t   base_addr_i,
    output wl_layer_pkg::load_cnt_t load_cnt_o,
    output wl_glb_pkg::glb_addr_t   glb_addr_o
);

    // edges seen since the load level went high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_cnt_o <= '0;
        end else if (load_state_i) begin
            load_cnt_o <= load_cnt_o + 1'b1;
        end else begin
            load_cnt_o <= '0;
        end
    end

    // byte address, base appears with count 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            glb_addr_o <= '0;
        end else if (!load_state_i) begin
            glb_addr_o <= '0;
        end else if (load_cnt_o == '0) begin
            glb_addr_o <= base_addr_i;         // first cycle of a load
        end else begin
            glb_addr_o <= glb_addr_o + 1'b1;   // one byte per cycle
        end
    end

    // addresses stay contiguous for the whole load
    a_addr_step : assert property (
        @(posedge clk) disable iff (!rst_n)
        (load_state_i && load_cnt_o >= 2)
            |-> (glb_addr_o == $past(glb_addr_o) + 32'd1)
    );

endmodule

// File: src/wl_glb_pkg.sv
`include "wl_consts.svh"

package wl_glb_pkg;

    typedef logic [`WL_GLB_ADDR_W-1:0] glb_addr_t;
    typedef logic [`WL_GLB_DATA_W-1:0] glb_word_t;

    // byte position inside a glb word, lane 0 is the low byte
    typedef enum logic [$clog2(`WL_GLB_DATA_W / `WL_WEIGHT_W)-1:0] {
        LANE0,
        LANE1,
        LANE2,
        LANE3
    } byte_lane_e;

endpackage

// File: src/wl_layer_pkg.sv
`include "wl_consts.svh"

package wl_layer_pkg;

    // standard and linear load no weights here
    typedef enum logic [1:0] {
        POINTWISE = 2'd0,
        DEPTHWISE = 2'd1,
        STANDARD  = 2'd2,
        LINEAR    = 2'd3
    } layer_type_e;

    typedef logic [`WL_CNT_W-1:0] load_cnt_t;

    typedef struct packed {
        logic [$clog2(`WL_PE_ROWS)-1:0] row;
        logic [$clog2(`WL_PE_COLS)-1:0] col;
        logic                           valid;
    } pe_coord_t;

    typedef logic [`WL_PE_ROWS-1:0][`WL_PE_COLS-1:0] pe_en_matrix_t;   // [row][col]

    typedef struct packed {
        logic [`WL_WEIGHT_W-1:0] weight;
        pe_en_matrix_t           en_matrix;
    } pe_load_t;

endpackage

// File: src/wl_consts.svh
`ifndef WL_CONSTS_SVH
`define WL_CONSTS_SVH

// pe array geometry
`define WL_PE_ROWS      32
`define WL_PE_COLS      32

// depthwise layout, one kernel per diagonal block
`define WL_DW_CHANNELS  10
`define WL_DW_KERNEL    3

// weights per supported layer type
`define WL_PW_WEIGHTS   1024
`define WL_DW_WEIGHTS   (`WL_DW_CHANNELS * `WL_DW_KERNEL * `WL_DW_KERNEL)

// glb bus
`define WL_GLB_ADDR_W   32   // byte address
`define WL_GLB_DATA_W   32
`define WL_GLB_RD_LAT   1    // cycles from address to returned word

`define WL_WEIGHT_W     8
`define WL_CNT_W        11   // holds pointwise count plus latency

`endif
